// ==== src/cheat_settings.svh ====
// **************************************************
// cheat engine sizes shared by the RTL and the
// testbench: program RAM, instruction and bus widths
// **************************************************

`ifndef CHEAT_SETTINGS_SVH
`define CHEAT_SETTINGS_SVH

// program RAM address width, 1024 instruction words
`define CHEAT_AW 10

// instruction width, 4-bit opcode plus 14-bit operand
`define CHEAT_IW 18

`define CHEAT_BW 14 // game memory byte address on the Wishbone port

`define CHEAT_DW 8  // game data is one byte wide

`endif

// ==== src/cheat_pkg.sv ====
// **************************************************
// cheat engine types: opcodes, core states, the
// instruction word and the Wishbone request bundle
// **************************************************

`include "cheat_settings.svh"

package cheat_pkg;

    // zero padding words in the program decode as a halt
    typedef enum logic [3:0] {
        OP_HALT = 4'h0,
        OP_LDI  = 4'h1, // acc takes operand[7:0]
        OP_ADDI = 4'h2, // acc takes acc + operand[7:0], wraps at 256
        OP_SETA = 4'h3, // address register takes the full operand
        OP_WR   = 4'h4, // bus write of acc to the address register
        OP_RD   = 4'h5, // bus read of the address register into acc
        OP_JNZ  = 4'h6  // pc takes operand[9:0] when acc is not zero
    } cheat_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,  // program RAM address presented
        S_DECODE, // RAM word valid, execute it
        S_BUS,    // waiting for the slave's ack
        S_HALT
    } core_state_e;

    // op in the top 4 bits, the operand fills the rest
    typedef struct packed {
        cheat_op_e                op;
        logic [`CHEAT_IW-5:0]     operand;
    } cheat_instr_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`CHEAT_BW-1:0] adr;
        logic [`CHEAT_DW-1:0] dat;
    } wb_req_t;

endpackage

// ==== src/cheat_prog_packer.sv ====
// **************************************************
// program loader, packs a byte stream into 18-bit
// instruction words, nine bytes make four words
// **************************************************

`include "cheat_settings.svh"

module cheat_prog_packer import cheat_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 prog_en,   // a rising edge restarts the load
    input  logic                 prog_wr,   // one byte per cycle while high
    input  logic [7:0]           prog_data,
    output logic                 wr_en,
    output logic [`CHEAT_AW-1:0] wr_addr,
    output cheat_instr_t         wr_word
);

    logic [15:0] fifo;    // leftover bits of the previous two bytes
    logic [3:0]  cnt;     // byte position inside a group of nine
    logic        last_en; // prog_en one cycle back, for edge detection
    logic        take;

    assign take = prog_wr & prog_en;

    // control state, cleared by reset and by the start of a new load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_en <= 1'b0;
            cnt     <= 4'd0;
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            last_en <= prog_en;
            if (prog_en && !last_en) begin
                cnt     <= 4'd0; // byte taken on the edge cycle is dropped
                wr_en   <= 1'b0;
                wr_addr <= '0;
            end else begin
                if (take) begin
                    cnt <= (cnt == 4'd8) ? 4'd0 : cnt + 4'd1;
                end
                // a word completes on the odd bytes 3, 5, 7 and 9 of the group
                wr_en <= take && (cnt == 4'd2 || cnt == 4'd4 ||
                                  cnt == 4'd6 || cnt == 4'd8);
                if (wr_en) begin
                    wr_addr <= wr_addr + 1'b1; // step once the word is written
                end
            end
        end
    end

    // the bit stream is little endian, so new bytes enter from the top
    always_ff @(posedge clk) begin
        if (take) begin
            fifo <= {prog_data, fifo[15:8]};
            case (cnt)
                4'd2:    wr_word <= {prog_data[1:0], fifo};       // 2 + 16 bits
                4'd4:    wr_word <= {prog_data[3:0], fifo[15:2]}; // 4 + 14 bits
                4'd6:    wr_word <= {prog_data[5:0], fifo[15:4]}; // 6 + 12 bits
                4'd8:    wr_word <= {prog_data, fifo[15:6]};      // 8 + 10 bits
                default: wr_word <= wr_word;
            endcase
        end
    end

endmodule

// ==== src/cheat_prog_ram.sv ====
// **************************************************
// program RAM, one write port for the loader and a
// registered read port for the core
// **************************************************

`include "cheat_settings.svh"

module cheat_prog_ram import cheat_pkg::*; (
    input  logic                 clk,
    input  logic                 wr_en,
    input  logic [`CHEAT_AW-1:0] wr_addr,
    input  cheat_instr_t         wr_word,
    input  logic [`CHEAT_AW-1:0] rd_addr,
    output cheat_instr_t         rd_word
);

    localparam int DEPTH = 1 << `CHEAT_AW;

    // plain array so that synthesis maps it to block RAM
    cheat_instr_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // read data arrives the cycle after the address
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_addr];
    end

endmodule

// ==== src/cheat_core.sv ====
// **************************************************
// cheat sequencer, fetches from program RAM, runs
// one accumulator and drives a Wishbone master
// **************************************************

`include "cheat_settings.svh"

module cheat_core import cheat_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 prog_en,  // holds the core idle during a load
    input  cheat_instr_t         rd_word,
    input  logic                 wb_ack,
    input  logic [`CHEAT_DW-1:0] wb_dat_i,
    output logic [`CHEAT_AW-1:0] rd_addr,
    output wb_req_t              wb_out,
    output logic                 halted
);

    core_state_e          state;
    logic [`CHEAT_AW-1:0] pc;
    logic [`CHEAT_DW-1:0] acc;      // the only data register
    logic [`CHEAT_BW-1:0] addr_reg; // game memory pointer for OP_WR and OP_RD

    assign rd_addr = pc; // RAM registers it during S_FETCH

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            pc     <= '0;
            wb_out <= '0;
            halted <= 1'b0;
        end else if (prog_en) begin
            // a load overrides everything, including a bus cycle in flight
            state      <= S_IDLE;
            pc         <= '0;
            wb_out.cyc <= 1'b0;
            wb_out.stb <= 1'b0;
            wb_out.we  <= 1'b0;
            halted     <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    pc    <= '0;      // every run starts at word 0
                    state <= S_FETCH;
                end
                S_FETCH: begin
                    state <= S_DECODE;
                end
                S_DECODE: begin
                    pc    <= pc + 1'b1; // overridden below by a taken jump or halt
                    state <= S_FETCH;
                    case (rd_word.op)
                        OP_LDI, OP_ADDI, OP_SETA: ; // handled in the data block
                        OP_WR: begin
                            wb_out.cyc <= 1'b1;
                            wb_out.stb <= 1'b1;
                            wb_out.we  <= 1'b1;
                            wb_out.adr <= addr_reg;
                            wb_out.dat <= acc;
                            state      <= S_BUS;
                        end
                        OP_RD: begin
                            wb_out.cyc <= 1'b1;
                            wb_out.stb <= 1'b1;
                            wb_out.we  <= 1'b0;
                            wb_out.adr <= addr_reg;
                            state      <= S_BUS;
                        end
                        OP_JNZ: begin
                            if (acc != '0) begin
                                pc <= rd_word.operand[`CHEAT_AW-1:0];
                            end
                        end
                        default: begin
                            // OP_HALT and every unused code end the run
                            pc     <= pc;
                            halted <= 1'b1;
                            state  <= S_HALT;
                        end
                    endcase
                end
                S_BUS: begin
                    if (wb_ack) begin // single access, done on the first ack
                        wb_out.cyc <= 1'b0;
                        wb_out.stb <= 1'b0;
                        wb_out.we  <= 1'b0;
                        state      <= S_FETCH;
                    end
                end
                S_HALT: ; // stays here until the next load
                default: state <= S_IDLE;
            endcase
        end
    end

    // data path registers, only written by the instructions that own them
    always_ff @(posedge clk) begin
        if (!prog_en && state == S_DECODE) begin
            case (rd_word.op)
                OP_LDI:  acc      <= rd_word.operand[`CHEAT_DW-1:0];
                OP_ADDI: acc      <= acc + rd_word.operand[`CHEAT_DW-1:0]; // wraps
                OP_SETA: addr_reg <= rd_word.operand[`CHEAT_BW-1:0];
                default: ;
            endcase
        end
        if (!prog_en && state == S_BUS && wb_ack && !wb_out.we) begin
            acc <= wb_dat_i; // read data lands on the ack edge
        end
    end

endmodule

// ==== src/cheat_top.sv ====
// **************************************************
// cheat engine top, loader and program RAM feeding
// the sequencer core and its Wishbone port
// **************************************************

`include "cheat_settings.svh"

module cheat_top import cheat_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 prog_en,
    input  logic                 prog_wr,
    input  logic [7:0]           prog_data,
    input  logic                 wb_ack,
    input  logic [`CHEAT_DW-1:0] wb_dat_i,
    output wb_req_t              wb_out,
    output logic                 halted
);

    logic                 wr_en;
    logic [`CHEAT_AW-1:0] wr_addr;
    cheat_instr_t         wr_word;
    logic [`CHEAT_AW-1:0] rd_addr;
    cheat_instr_t         rd_word;

    cheat_prog_packer u_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_word   (wr_word)
    );

    cheat_prog_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_word (wr_word),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    cheat_core u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .prog_en  (prog_en),
        .rd_word  (rd_word),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .rd_addr  (rd_addr),
        .wb_out   (wb_out),
        .halted   (halted)
    );

endmodule

// ==== tb/cheat_assert.sv ====
// **************************************************
// bound checks on the Wishbone master handshake and
// the loader's word write strobe
// **************************************************

`include "cheat_settings.svh"

module cheat_assert import cheat_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    prog_en,
    input wb_req_t wb_out,
    input logic    wb_ack,
    input logic    wr_en
);

    int fail_count = 0;

    // a strobe only makes sense inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_out.stb |-> wb_out.cyc)
        else begin
            $error("wb stb high while cyc is low");
            fail_count++;
        end

    a_cyc_with_stb: assert property (@(posedge clk) disable iff (!rst_n || prog_en)
        $rose(wb_out.stb) |-> $rose(wb_out.cyc)) // both rise on the same edge
        else begin
            $error("wb stb rose without cyc rising with it");
            fail_count++;
        end

    // request must not move until the slave acks
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n || prog_en)
        (wb_out.stb && !wb_ack) |=>
            ($stable(wb_out.adr) && $stable(wb_out.we) && $stable(wb_out.dat)))
        else begin
            $error("wb adr, we or dat changed while waiting for ack");
            fail_count++;
        end

    a_single_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |=> !wr_en) // words complete at least two bytes apart
        else begin
            $error("packer wr_en high on two cycles in a row");
            fail_count++;
        end

endmodule

bind cheat_top cheat_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .prog_en (prog_en),
    .wb_out  (wb_out),
    .wb_ack  (wb_ack),
    .wr_en   (wr_en)
);

// ==== tb/cheat_tb.sv ====
// **************************************************
// cheat engine testbench, loads each program of a
// table, models the Wishbone slave and checks every
// bus access and the halt against the table
// **************************************************

`include "cheat_settings.svh"

module cheat_tb import cheat_pkg::*; ();

    localparam int NPROG   = 5;
    localparam int MAXW    = 16;  // words per program, before padding
    localparam int MAXA    = 8;   // listed bus accesses per program
    localparam int TIMEOUT = 400; // cycles allowed for one run to halt

    logic                 clk;
    logic                 rst_n;
    logic                 prog_en;
    logic                 prog_wr;
    logic [7:0]           prog_data;
    logic                 wb_ack;
    logic [`CHEAT_DW-1:0] wb_dat_i;
    wb_req_t              wb_out;
    logic                 halted;

    // program table, the expected accesses of each program sit next to it
    cheat_instr_t         prog_words [NPROG][MAXW];
    int                   prog_len   [NPROG];
    bit                   rand_ack   [NPROG]; // random ack delay for this program
    logic                 exp_we     [NPROG][MAXA];
    logic [`CHEAT_BW-1:0] exp_adr    [NPROG][MAXA];
    logic [`CHEAT_DW-1:0] exp_dat    [NPROG][MAXA];
    int                   exp_cnt    [NPROG];

    logic [7:0] game_mem [1 << `CHEAT_BW]; // slave model memory, 16K bytes
    int         cur_prog;
    int         acc_idx;  // accesses seen so far in the current run
    int         errors;
    int         checks;
    bit         busy;     // slave has seen the request and counts down
    int         wait_cnt;

    cheat_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .wb_ack    (wb_ack),
        .wb_dat_i  (wb_dat_i),
        .wb_out    (wb_out),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    task automatic add_instr(input int p, input cheat_op_e op, input logic [`CHEAT_IW-5:0] arg);
        prog_words[p][prog_len[p]] = '{op: op, operand: arg};
        prog_len[p]++;
    endtask

    task automatic add_access(input int p, input logic we, input logic [`CHEAT_BW-1:0] adr,
                              input logic [`CHEAT_DW-1:0] dat);
        exp_we[p][exp_cnt[p]]  = we;
        exp_adr[p][exp_cnt[p]] = adr;
        exp_dat[p][exp_cnt[p]] = dat; // for a read this is the value the slave returns
        exp_cnt[p]++;
    endtask

    task automatic build_table();
        int a;
        for (a = 0; a < NPROG; a++) begin
            prog_len[a] = 0;
            exp_cnt[a]  = 0;
            rand_ack[a] = (a >= 3); // the last two programs see back-pressure
        end
        // fill pattern mixes both halves of the address
        for (a = 0; a < (1 << `CHEAT_BW); a++) begin
            game_mem[a] = a[7:0] ^ {2'b01, a[13:8]};
        end
        game_mem[14'h0123] = 8'hF0; // read by program 1
        game_mem[14'h0456] = 8'h11;
        game_mem[14'h3A01] = 8'h7E; // read by program 3
        // program 0 has 9 words, so the packer sees three padded groups
        add_instr(0, OP_SETA, 14'h2A5C);
        add_instr(0, OP_LDI,  14'h0096);
        add_instr(0, OP_WR,   14'h0000);
        add_instr(0, OP_SETA, 14'h3FFF);
        add_instr(0, OP_LDI,  14'h2B71); // upper operand bits must be ignored
        add_instr(0, OP_WR,   14'h0000);
        add_instr(0, OP_ADDI, 14'h1234); // 0x71 + 0x34
        add_instr(0, OP_WR,   14'h0000);
        add_instr(0, OP_HALT, 14'h0000);
        add_access(0, 1'b1, 14'h2A5C, 8'h96);
        add_access(0, 1'b1, 14'h3FFF, 8'h71);
        add_access(0, 1'b1, 14'h3FFF, 8'hA5);
        // read-modify-write, both sums wrap at 256
        add_instr(1, OP_SETA, 14'h0123);
        add_instr(1, OP_RD,   14'h0000);
        add_instr(1, OP_ADDI, 14'h0025);
        add_instr(1, OP_WR,   14'h0000);
        add_instr(1, OP_SETA, 14'h0456);
        add_instr(1, OP_RD,   14'h0000);
        add_instr(1, OP_ADDI, 14'h00FF);
        add_instr(1, OP_WR,   14'h0000);
        add_instr(1, OP_HALT, 14'h0000);
        add_access(1, 1'b0, 14'h0123, 8'hF0);
        add_access(1, 1'b1, 14'h0123, 8'h15);
        add_access(1, 1'b0, 14'h0456, 8'h11);
        add_access(1, 1'b1, 14'h0456, 8'h10);
        // countdown from 3, the jump goes back to the write
        add_instr(2, OP_SETA, 14'h0200);
        add_instr(2, OP_LDI,  14'h0003);
        add_instr(2, OP_WR,   14'h0000);
        add_instr(2, OP_ADDI, 14'h00FF);
        add_instr(2, OP_JNZ,  14'h0002);
        add_instr(2, OP_HALT, 14'h0000);
        add_access(2, 1'b1, 14'h0200, 8'h03);
        add_access(2, 1'b1, 14'h0200, 8'h02);
        add_access(2, 1'b1, 14'h0200, 8'h01);
        // mixed reads and writes under random ack delay
        add_instr(3, OP_SETA, 14'h3A01);
        add_instr(3, OP_RD,   14'h0000);
        add_instr(3, OP_SETA, 14'h0010);
        add_instr(3, OP_WR,   14'h0000);
        add_instr(3, OP_ADDI, 14'h0002);
        add_instr(3, OP_WR,   14'h0000);
        add_instr(3, OP_RD,   14'h0000); // reads back what the core just wrote
        add_instr(3, OP_SETA, 14'h3A01);
        add_instr(3, OP_ADDI, 14'h0081);
        add_instr(3, OP_WR,   14'h0000);
        add_instr(3, OP_HALT, 14'h0000);
        add_access(3, 1'b0, 14'h3A01, 8'h7E);
        add_access(3, 1'b1, 14'h0010, 8'h7E);
        add_access(3, 1'b1, 14'h0010, 8'h80);
        add_access(3, 1'b0, 14'h0010, 8'h80);
        add_access(3, 1'b1, 14'h3A01, 8'h01);
        // short reload, words 4 and up still hold program 3
        add_instr(4, OP_LDI,  14'h005A);
        add_instr(4, OP_SETA, 14'h0777);
        add_instr(4, OP_WR,   14'h0000);
        add_instr(4, OP_HALT, 14'h0000);
        add_access(4, 1'b1, 14'h0777, 8'h5A);
    endtask

    // byte stream is little endian, word k sits at bits 18k of each 72-bit group
    task automatic load_program(input int p);
        logic [71:0] group;
        int          n_words;
        int          g;
        int          k;
        int          b;
        n_words = (prog_len[p] + 3) / 4 * 4; // zero words pad the last group
        prog_en = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        for (g = 0; g < n_words; g = g + 4) begin
            group = '0;
            for (k = 0; k < 4; k++) begin
                if (g + k < prog_len[p]) begin
                    group[18*k +: 18] = prog_words[p][g + k];
                end
            end
            for (b = 0; b < 9; b++) begin
                prog_wr   = 1'b1;
                prog_data = group[8*b +: 8];
                @(posedge clk);
                #1;
            end
        end
        prog_wr   = 1'b0;
        prog_data = 8'h00;
        repeat (3) begin // the last word is written after its byte
            @(posedge clk);
            #1;
        end
        assert (halted == 1'b0) else begin
            $display("Mismatch at %0t: halted = %b, expected 0 during load", $time, halted);
            errors++;
        end
        prog_en = 1'b0;
    endtask

    task automatic wait_halted(input int p);
        int cycles;
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (halted) else begin
            $display("Timeout: program %0d did not halt within %0d cycles", p, TIMEOUT);
            errors++;
        end
    endtask

    // called by the slave on the cycle it raises ack
    task automatic complete_access();
        int i;
        i = acc_idx;
        if (i >= exp_cnt[cur_prog]) begin
            $display("Unexpected bus access at %0t to address %h in program %0d",
                     $time, wb_out.adr, cur_prog);
            errors++;
        end else begin
            checks++;
            assert (wb_out.we == exp_we[cur_prog][i]) else begin
                $display("Mismatch at %0t: wb_out.we = %b, expected %b",
                         $time, wb_out.we, exp_we[cur_prog][i]);
                errors++;
            end
            assert (wb_out.adr == exp_adr[cur_prog][i]) else begin
                $display("Mismatch at %0t: wb_out.adr = %h, expected %h",
                         $time, wb_out.adr, exp_adr[cur_prog][i]);
                errors++;
            end
            if (wb_out.we) begin
                assert (wb_out.dat == exp_dat[cur_prog][i]) else begin
                    $display("Mismatch at %0t: wb_out.dat = %h, expected %h",
                             $time, wb_out.dat, exp_dat[cur_prog][i]);
                    errors++;
                end
            end else begin
                // catches an earlier write that landed with the wrong data
                assert (game_mem[wb_out.adr] == exp_dat[cur_prog][i]) else begin
                    $display("Mismatch at %0t: game_mem read data = %h, expected %h",
                             $time, game_mem[wb_out.adr], exp_dat[cur_prog][i]);
                    errors++;
                end
            end
        end
        if (wb_out.we) begin
            game_mem[wb_out.adr] = wb_out.dat;
        end else begin
            wb_dat_i = game_mem[wb_out.adr];
        end
        acc_idx++;
    endtask

    // slave waits 0 to 3 cycles, then acks for exactly one cycle
    always @(posedge clk) begin
        #1;
        if (wb_ack) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_out.cyc && wb_out.stb) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = rand_ack[cur_prog] ? int'($urandom % 4) : 0;
            end
            if (wait_cnt == 0) begin
                complete_access();
                wb_ack = 1'b1;
            end else begin
                wait_cnt--;
            end
        end
    end

    initial begin
        int p;
        int fails;
        void'($urandom(36));
        clk       = 1'b0;
        rst_n     = 1'b0;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_data = 8'h00;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        busy      = 1'b0;
        wait_cnt  = 0;
        cur_prog  = 0;
        acc_idx   = 0;
        errors    = 0;
        checks    = 0;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        assert ({wb_out.cyc, wb_out.stb, wb_out.we, halted} == 4'b0000) else begin
            $display("Mismatch at %0t: {cyc,stb,we,halted} = %b, expected 0000 in reset",
                     $time, {wb_out.cyc, wb_out.stb, wb_out.we, halted});
            errors++;
        end
        rst_n = 1'b1;
        for (p = 0; p < NPROG; p++) begin
            cur_prog = p;
            acc_idx  = 0;
            load_program(p);
            wait_halted(p);
            repeat (4) begin // nothing may follow the halt
                @(posedge clk);
                #1;
            end
            assert (halted) else begin
                $display("Mismatch at %0t: halted = %b, expected 1 after halt", $time, halted);
                errors++;
            end
            assert (acc_idx == exp_cnt[p]) else begin
                $display("Mismatch at %0t: access count = %0d, expected %0d in program %0d",
                         $time, acc_idx, exp_cnt[p], p);
                errors++;
            end
        end
        fails = UUT.u_assert.fail_count;
        $display("accesses checked: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, fails);
        if (errors + fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/cheat_pkg.sv
src/cheat_prog_packer.sv
src/cheat_prog_ram.sv
src/cheat_core.sv
src/cheat_top.sv
tb/cheat_assert.sv
tb/cheat_tb.sv

// ==== Makefile ====
# Verilator build and run of the cheat engine testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cheat_tb \
		-f sources.f --Mdir obj_dir -o Vcheat_tb
	./obj_dir/Vcheat_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Errors found" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
